/* verilog/vdp_pkg.sv */
// ********************
// register map, copper program word and common widths
// shared by the vdp RTL and its testbench
// ********************

package vdp_pkg;

    typedef logic [5:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [3:0] color_t;
    typedef logic [9:0] beam_t;

    // register numbers
    localparam reg_addr_t reg_bg_color = 6'd0;
    localparam reg_addr_t reg_cop_ctrl = 6'd1;
    localparam reg_addr_t reg_cop_addr = 6'd2;
    localparam reg_addr_t reg_cop_lo = 6'd3;
    localparam reg_addr_t reg_cop_hi = 6'd4;
    localparam reg_addr_t reg_status_line = 6'd5;
    localparam reg_addr_t reg_status_pc = 6'd6;
    localparam reg_addr_t reg_layer_base = 6'd8;
    localparam int reg_layer_stride = 4;

    // offsets inside one layer group
    localparam logic [1:0] layer_scroll_x = 2'd0;
    localparam logic [1:0] layer_scroll_y = 2'd1;
    localparam logic [1:0] layer_color = 2'd2;
    localparam logic [1:0] layer_ctrl = 2'd3;

    localparam int cop_depth = 16;
    localparam int cop_pc_width = $clog2(cop_depth);

    localparam logic cop_op_wait = 1'b0;
    localparam logic cop_op_write = 1'b1;

    typedef struct packed {
        logic op;
        logic [20:0] pad;
        beam_t line;
    } cop_wait_t;

    typedef struct packed {
        logic op;
        logic [8:0] pad;
        reg_addr_t address;
        reg_data_t data;
    } cop_write_t;

    // one program word, decoded by its top bit
    typedef union packed {
        cop_wait_t wait_view;
        cop_write_t write_view;
    } cop_word_t;

endpackage

/* verilog/vdp_raster.sv */
// ********************
// beam position counters with line and frame markers
// ********************

`timescale 1ns/1ns

module vdp_raster #(
    parameter int h_total = 24,
    parameter int v_total = 10
) (
    input  logic clk,
    input  logic reset,

    output vdp_pkg::beam_t beam_x,
    output vdp_pkg::beam_t beam_y,
    output logic line_start,
    output logic frame_start
);
    import vdp_pkg::*;

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = beam_x == beam_t'(h_total - 1);
    assign y_wrap = beam_y == beam_t'(v_total - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            beam_x <= '0;
            beam_y <= '0;
        end else if (x_wrap) begin
            beam_x <= '0;
            beam_y <= y_wrap ? '0 : beam_y + 1'b1;
        end else begin
            beam_x <= beam_x + 1'b1;
        end
    end

    assign line_start = beam_x == '0;
    assign frame_start = line_start && beam_y == '0;

endmodule

/* verilog/vdp_host_interface.sv */
// ********************
// wishbone classic slave for the vdp registers
// merges cpu and copper writes into one register stream
// and answers cpu status reads
// ********************

`timescale 1ns/1ns

module vdp_host_interface (
    input  logic clk,
    input  logic reset,

    // wishbone classic slave
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  vdp_pkg::reg_addr_t wb_adr,
    input  vdp_pkg::reg_data_t wb_dat_w,
    output vdp_pkg::reg_data_t wb_dat_r,
    output logic wb_ack,

    // copper write request
    input  logic cop_write_req,
    input  vdp_pkg::reg_addr_t cop_write_address,
    input  vdp_pkg::reg_data_t cop_write_data,
    output logic cop_write_grant,

    // status sources
    input  vdp_pkg::beam_t beam_y,
    input  logic [vdp_pkg::cop_pc_width-1:0] cop_pc,

    // register write stream
    output logic reg_write_en,
    output vdp_pkg::reg_addr_t reg_write_address,
    output vdp_pkg::reg_data_t reg_write_data
);
    import vdp_pkg::*;

    logic strobe_r;
    logic strobe_d;
    logic strobe_rise;
    logic busy;
    logic cpu_commit;
    reg_data_t status_data;

    // a new cycle is one whose strobe was low in the previous sample
    assign strobe_rise = strobe_r && !strobe_d;

    // busy marks the single wait cycle before ack
    assign cpu_commit = busy && wb_cyc && wb_stb && wb_we;

    // copper gets the stream whenever the cpu is not committing
    assign cop_write_grant = cop_write_req && !cpu_commit;

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_r <= 1'b0;
            strobe_d <= 1'b0;
            busy <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            // masking with ack lets a back-to-back cycle show a fresh edge
            strobe_r <= wb_cyc && wb_stb && !wb_ack;
            strobe_d <= strobe_r;
            busy <= strobe_rise;
            wb_ack <= busy;
        end
    end

    always_comb begin
        case (wb_adr)
            reg_status_line: status_data = reg_data_t'(beam_y);
            reg_status_pc: status_data = reg_data_t'(cop_pc);
            default: status_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            wb_dat_r <= status_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_en <= 1'b0;
        end else begin
            reg_write_en <= cpu_commit || cop_write_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_commit) begin
            reg_write_address <= wb_adr;
            reg_write_data <= wb_dat_w;
        end else if (cop_write_grant) begin
            reg_write_address <= cop_write_address;
            reg_write_data <= cop_write_data;
        end
    end

    // a copper request held off by a cpu commit goes through on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        cop_write_req && cpu_commit |=> cop_write_grant);

endmodule

/* verilog/vdp_copper.sv */
// ********************
// copper: program memory loaded through registers,
// runs wait and write words once per frame
// ********************

`timescale 1ns/1ns

module vdp_copper #(
    parameter int v_total = 10
) (
    input  logic clk,
    input  logic reset,

    input  logic reg_write_en,
    input  vdp_pkg::reg_addr_t reg_write_address,
    input  vdp_pkg::reg_data_t reg_write_data,

    input  logic line_start,
    input  logic frame_start,
    input  vdp_pkg::beam_t beam_y,

    input  logic cop_write_grant,
    output logic cop_write_req,
    output vdp_pkg::reg_addr_t cop_write_address,
    output vdp_pkg::reg_data_t cop_write_data,
    output logic [vdp_pkg::cop_pc_width-1:0] cop_pc
);
    import vdp_pkg::*;

    cop_word_t program_mem [cop_depth];
    cop_word_t current;
    reg_data_t word_lo;
    logic [cop_pc_width-1:0] load_addr;
    logic enable;
    logic running;
    logic restart;

    assign current = program_mem[cop_pc];

    // loader registers
    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            load_addr <= '0;
        end else if (reg_write_en) begin
            case (reg_write_address)
                reg_cop_ctrl: enable <= reg_write_data[0];
                reg_cop_addr: load_addr <= reg_write_data[cop_pc_width-1:0];
                reg_cop_hi: load_addr <= load_addr + 1'b1;
                default: ;
            endcase
        end
    end

    // the high half commits the whole word
    always_ff @(posedge clk) begin
        if (reg_write_en && reg_write_address == reg_cop_lo) begin
            word_lo <= reg_write_data;
        end
        if (reg_write_en && reg_write_address == reg_cop_hi) begin
            program_mem[load_addr] <= {reg_write_data, word_lo};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cop_pc <= '0;
            running <= 1'b0;
            restart <= 1'b0;
            cop_write_req <= 1'b0;
        end else if (cop_write_req) begin
            // hold the request until the host takes it
            if (cop_write_grant) begin
                cop_write_req <= 1'b0;
                cop_pc <= cop_pc + 1'b1;
            end
            if (frame_start) begin
                restart <= 1'b1;
            end
        end else if (!enable) begin
            cop_pc <= '0;
            running <= 1'b0;
            restart <= 1'b0;
        end else if (frame_start || restart) begin
            cop_pc <= '0;
            running <= 1'b1;
            restart <= 1'b0;
        end else if (running) begin
            if (current.write_view.op == cop_op_write) begin
                cop_write_req <= 1'b1;
                cop_write_address <= current.write_view.address;
                cop_write_data <= current.write_view.data;
            end else if (current.wait_view.line >= beam_t'(v_total)) begin
                // line never comes, sleep until the next frame
                running <= 1'b0;
            end else if (beam_y == current.wait_view.line) begin
                cop_pc <= cop_pc + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        cop_write_req && !cop_write_grant |=>
            cop_write_req && $stable(cop_write_address) && $stable(cop_write_data));

    // restart relies on the raster marking frames on a line start of line 0
    assert property (@(posedge clk) disable iff (reset)
        frame_start |-> line_start && beam_y == '0);

endmodule

/* verilog/vdp_layer.sv */
// ********************
// one scroll layer: four registers and a two-tone
// checker pattern, one pixel per clock
// ********************

`timescale 1ns/1ns

module vdp_layer #(
    parameter int layer_index = 0
) (
    input  logic clk,
    input  logic reset,

    input  logic reg_write_en,
    input  vdp_pkg::reg_addr_t reg_write_address,
    input  vdp_pkg::reg_data_t reg_write_data,

    input  vdp_pkg::beam_t beam_x,
    input  vdp_pkg::beam_t beam_y,

    output vdp_pkg::color_t layer_pixel,
    output logic layer_opaque
);
    import vdp_pkg::*;

    localparam reg_addr_t group_base =
        reg_addr_t'(reg_layer_base + layer_index * reg_layer_stride);

    beam_t scroll_x;
    beam_t scroll_y;
    color_t color;
    logic enable;
    logic [2:0] shift;
    logic group_hit;
    beam_t x_sum;
    beam_t y_sum;

    // groups are four registers wide, so the low two bits pick the register
    assign group_hit = reg_write_en && reg_write_address[5:2] == group_base[5:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            shift <= '0;
        end else if (group_hit && reg_write_address[1:0] == layer_ctrl) begin
            enable <= reg_write_data[0];
            shift <= reg_write_data[3:1];
        end
    end

    always_ff @(posedge clk) begin
        if (group_hit) begin
            case (reg_write_address[1:0])
                layer_scroll_x: scroll_x <= reg_write_data[9:0];
                layer_scroll_y: scroll_y <= reg_write_data[9:0];
                layer_color: color <= reg_write_data[3:0];
                default: ;
            endcase
        end
    end

    assign x_sum = beam_x + scroll_x;
    assign y_sum = beam_y + scroll_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            layer_opaque <= 1'b0;
        end else begin
            layer_opaque <= enable && (x_sum[shift] ^ y_sum[shift]);
        end
    end

    always_ff @(posedge clk) begin
        layer_pixel <= color;
    end

endmodule

/* verilog/vdp_mixer.sv */
// ********************
// picks the lowest numbered opaque layer per pixel,
// falls back to the background color register
// ********************

`timescale 1ns/1ns

module vdp_mixer #(
    parameter int layer_count = 4
) (
    input  logic clk,
    input  logic reset,

    input  logic reg_write_en,
    input  vdp_pkg::reg_addr_t reg_write_address,
    input  vdp_pkg::reg_data_t reg_write_data,

    input  vdp_pkg::color_t [layer_count-1:0] layer_pixel,
    input  logic [layer_count-1:0] layer_opaque,
    input  vdp_pkg::beam_t beam_x,
    input  vdp_pkg::beam_t beam_y,

    output vdp_pkg::color_t pixel,
    output vdp_pkg::beam_t pixel_x,
    output vdp_pkg::beam_t pixel_y
);
    import vdp_pkg::*;

    color_t bg_color;
    color_t mixed;
    beam_t beam_x_d;
    beam_t beam_y_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            bg_color <= '0;
        end else if (reg_write_en && reg_write_address == reg_bg_color) begin
            bg_color <= reg_write_data[3:0];
        end
    end

    // walk from the top so layer 0 ends up with the last word
    always_comb begin
        mixed = bg_color;
        for (int i = layer_count - 1; i >= 0; i--) begin
            if (layer_opaque[i]) begin
                mixed = layer_pixel[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel <= '0;
        end else begin
            pixel <= mixed;
        end
    end

    // one stage for the layers, one for this register
    always_ff @(posedge clk) begin
        beam_x_d <= beam_x;
        beam_y_d <= beam_y;
        pixel_x <= beam_x_d;
        pixel_y <= beam_y_d;
    end

endmodule

/* verilog/vdp_top.sv */
// ********************
// vdp register subsystem top: raster, host interface,
// copper, scroll layers and mixer
// ********************

`timescale 1ns/1ns

module vdp_top #(
    parameter int layer_count = 4,
    parameter int h_total = 24,
    parameter int v_total = 10
) (
    input  logic clk,
    input  logic reset,

    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  vdp_pkg::reg_addr_t wb_adr,
    input  vdp_pkg::reg_data_t wb_dat_w,
    output vdp_pkg::reg_data_t wb_dat_r,
    output logic wb_ack,

    output vdp_pkg::color_t pixel,
    output vdp_pkg::beam_t pixel_x,
    output vdp_pkg::beam_t pixel_y
);
    import vdp_pkg::*;

    beam_t beam_x;
    beam_t beam_y;
    logic line_start;
    logic frame_start;

    logic reg_write_en;
    reg_addr_t reg_write_address;
    reg_data_t reg_write_data;

    logic cop_write_req;
    logic cop_write_grant;
    reg_addr_t cop_write_address;
    reg_data_t cop_write_data;
    logic [cop_pc_width-1:0] cop_pc;

    color_t [layer_count-1:0] layer_pixel;
    logic [layer_count-1:0] layer_opaque;

    vdp_raster #(
        .h_total(h_total),
        .v_total(v_total)
    ) u_raster (
        .clk(clk),
        .reset(reset),
        .beam_x(beam_x),
        .beam_y(beam_y),
        .line_start(line_start),
        .frame_start(frame_start)
    );

    vdp_host_interface u_host (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .cop_write_req(cop_write_req),
        .cop_write_address(cop_write_address),
        .cop_write_data(cop_write_data),
        .cop_write_grant(cop_write_grant),
        .beam_y(beam_y),
        .cop_pc(cop_pc),
        .reg_write_en(reg_write_en),
        .reg_write_address(reg_write_address),
        .reg_write_data(reg_write_data)
    );

    vdp_copper #(
        .v_total(v_total)
    ) u_copper (
        .clk(clk),
        .reset(reset),
        .reg_write_en(reg_write_en),
        .reg_write_address(reg_write_address),
        .reg_write_data(reg_write_data),
        .line_start(line_start),
        .frame_start(frame_start),
        .beam_y(beam_y),
        .cop_write_grant(cop_write_grant),
        .cop_write_req(cop_write_req),
        .cop_write_address(cop_write_address),
        .cop_write_data(cop_write_data),
        .cop_pc(cop_pc)
    );

    for (genvar i = 0; i < layer_count; i++) begin : g_layer
        vdp_layer #(
            .layer_index(i)
        ) u_layer (
            .clk(clk),
            .reset(reset),
            .reg_write_en(reg_write_en),
            .reg_write_address(reg_write_address),
            .reg_write_data(reg_write_data),
            .beam_x(beam_x),
            .beam_y(beam_y),
            .layer_pixel(layer_pixel[i]),
            .layer_opaque(layer_opaque[i])
        );
    end

    vdp_mixer #(
        .layer_count(layer_count)
    ) u_mixer (
        .clk(clk),
        .reset(reset),
        .reg_write_en(reg_write_en),
        .reg_write_address(reg_write_address),
        .reg_write_data(reg_write_data),
        .layer_pixel(layer_pixel),
        .layer_opaque(layer_opaque),
        .beam_x(beam_x),
        .beam_y(beam_y),
        .pixel(pixel),
        .pixel_x(pixel_x),
        .pixel_y(pixel_y)
    );

endmodule

/* bench/vdp_tb.sv */
// ********************
// testbench for the vdp register subsystem
// drives a table of wishbone transactions and checks
// every pixel against a model of the layers and mixer
// ********************

`timescale 1ns/1ns

module vdp_tb;
    import vdp_pkg::*;

    localparam int layer_count = 4;
    localparam int h_total = 24;
    localparam int v_total = 10;
    localparam int frame_cycles = h_total * v_total;
    localparam int chk_none = 0;
    localparam int chk_value = 1;
    localparam int chk_line = 2;
    localparam color_t copper_color = 4'd9;

    typedef struct {
        logic we;
        reg_addr_t address;
        reg_data_t data;
        int check;
        reg_data_t expected;
        int sync_line;
        int frames;
    } step_t;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    reg_addr_t wb_adr;
    reg_data_t wb_dat_w;
    reg_data_t wb_dat_r;
    logic wb_ack;
    color_t pixel;
    beam_t pixel_x;
    beam_t pixel_y;

    step_t steps[$];
    logic steps_ready;
    logic [31:0] lfsr_state;

    // model of the beam and its two pipeline stages
    beam_t track_bx;
    beam_t track_by;
    beam_t track_x1;
    beam_t track_y1;
    beam_t track_px;
    beam_t track_py;
    logic track_valid;

    // register shadow written by the table
    color_t shadow_bg;
    reg_data_t shadow_scroll_x [layer_count];
    reg_data_t shadow_scroll_y [layer_count];
    color_t shadow_color [layer_count];
    logic shadow_enable [layer_count];
    logic [2:0] shadow_shift [layer_count];
    logic cop_pending;
    logic cop_active;
    int quiet_count;

    vdp_top DUT (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .pixel(pixel),
        .pixel_x(pixel_x),
        .pixel_y(pixel_y)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    // right shifting galois lfsr with taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA300_0000;
        end
        return state >> 1;
    endfunction

    function automatic reg_data_t random_bits(input int count);
        reg_data_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic reg_addr_t layer_address(input int layer, input logic [1:0] offset);
        return reg_addr_t'(int'(reg_layer_base) + layer * reg_layer_stride + int'(offset));
    endfunction

    task automatic add_write(input reg_addr_t address, input reg_data_t data,
                             input int sync_line, input int frames);
        steps.push_back('{1'b1, address, data, chk_none, '0, sync_line, frames});
    endtask

    task automatic add_read(input reg_addr_t address, input int check, input reg_data_t expected,
                            input int sync_line, input int frames);
        steps.push_back('{1'b0, address, '0, check, expected, sync_line, frames});
    endtask

    task automatic build_steps();
        int shifts [3];
        cop_word_t prog_words [3];
        shifts = '{0, 2, 3};
        add_read(reg_status_pc, chk_value, 16'd0, -1, 0);
        add_read(reg_status_line, chk_line, '0, -1, 0);
        add_read(6'd7, chk_value, 16'd0, -1, 0);
        add_write(reg_bg_color, 16'd0, -1, 0);
        add_read(reg_status_line, chk_line, '0, 4, 1);
        // one layer with random scrolls at three pattern sizes
        for (int s = 0; s < 3; s++) begin
            add_write(layer_address(0, layer_scroll_x), random_bits(10), -1, 0);
            add_write(layer_address(0, layer_scroll_y), random_bits(10), -1, 0);
            add_write(layer_address(0, layer_color), reg_data_t'(6 + s), -1, 0);
            add_write(layer_address(0, layer_ctrl), reg_data_t'((shifts[s] << 1) | 1), -1, 1);
        end
        // several layers over a nonzero background
        add_write(reg_bg_color, 16'd3, -1, 0);
        add_write(layer_address(1, layer_scroll_x), random_bits(10), -1, 0);
        add_write(layer_address(1, layer_scroll_y), random_bits(10), -1, 0);
        add_write(layer_address(1, layer_color), 16'd10, -1, 0);
        add_write(layer_address(1, layer_ctrl), 16'h3, -1, 0);
        add_write(layer_address(2, layer_scroll_x), random_bits(10), -1, 0);
        add_write(layer_address(2, layer_scroll_y), random_bits(10), -1, 0);
        add_write(layer_address(2, layer_color), 16'd12, -1, 0);
        add_write(layer_address(2, layer_ctrl), 16'h1, -1, 1);
        add_read(reg_status_line, chk_line, '0, -1, 0);
        // copper program waits for line 3, recolors layer 0, then sleeps for the frame
        prog_words[0] = '0;
        prog_words[0].wait_view.op = cop_op_wait;
        prog_words[0].wait_view.line = beam_t'(3);
        prog_words[1] = '0;
        prog_words[1].write_view.op = cop_op_write;
        prog_words[1].write_view.address = layer_address(0, layer_color);
        prog_words[1].write_view.data = reg_data_t'(copper_color);
        prog_words[2] = '0;
        prog_words[2].wait_view.op = cop_op_wait;
        prog_words[2].wait_view.line = beam_t'(v_total);
        add_write(layer_address(0, layer_color), 16'd5, -1, 0);
        add_write(reg_cop_addr, 16'd0, -1, 0);
        for (int w = 0; w < 3; w++) begin
            add_write(reg_cop_lo, prog_words[w][15:0], -1, 0);
            add_write(reg_cop_hi, prog_words[w][31:16], -1, 0);
        end
        // enable on the last line so the copper starts with the next frame
        add_write(reg_cop_ctrl, 16'd1, v_total - 1, 0);
        // layer 3 stays disabled so these writes only load the bus
        for (int b = 0; b < 12; b++) begin
            add_write(layer_address(3, layer_scroll_x), random_bits(10), (b == 0) ? 2 : -1, 0);
        end
        add_read(reg_status_pc, chk_value, 16'd2, -1, 0);
        add_read(reg_status_line, chk_line, '0, -1, 2);
    endtask

    task automatic update_shadow(input reg_addr_t address, input reg_data_t data);
        int layer;
        int offset;
        quiet_count = 4;
        if (address == reg_bg_color) begin
            shadow_bg = data[3:0];
        end
        if (address == reg_cop_ctrl && data[0]) begin
            cop_pending = 1'b1;
        end
        if (int'(address) >= int'(reg_layer_base) &&
            int'(address) < int'(reg_layer_base) + layer_count * reg_layer_stride) begin
            layer = (int'(address) - int'(reg_layer_base)) / reg_layer_stride;
            offset = (int'(address) - int'(reg_layer_base)) % reg_layer_stride;
            case (offset)
                0: shadow_scroll_x[layer] = data;
                1: shadow_scroll_y[layer] = data;
                2: shadow_color[layer] = data[3:0];
                default: begin
                    shadow_enable[layer] = data[0];
                    shadow_shift[layer] = data[3:1];
                end
            endcase
        end
    endtask

    // one wishbone classic cycle entered and left on a falling edge
    task automatic bus_cycle(input step_t s);
        int wait_count;
        reg_data_t read_data;
        reg_data_t line_then;
        wait_count = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = s.we;
        wb_adr = s.address;
        wb_dat_w = s.data;
        do begin
            @(negedge clk);
            wait_count++;
            assert (wait_count < 8) else report_problem("wishbone cycle was never acknowledged");
        end while (!wb_ack);
        read_data = wb_dat_r;
        // status is sampled in the cycle before ack
        line_then = reg_data_t'(track_y1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (s.we) begin
            update_shadow(s.address, s.data);
        end
        @(negedge clk);
        assert (wb_ack == 1'b0) else report_mismatch("wb_ack", wb_ack, 0);
        if (s.check == chk_value) begin
            assert (read_data == s.expected) else report_mismatch("wb_dat_r", read_data, s.expected);
        end
        if (s.check == chk_line) begin
            assert (read_data == line_then) else report_mismatch("wb_dat_r", read_data, line_then);
        end
    endtask

    function automatic color_t expected_pixel(input beam_t x, input beam_t y);
        beam_t xs;
        beam_t ys;
        color_t result;
        logic found;
        result = shadow_bg;
        found = 1'b0;
        for (int i = 0; i < layer_count; i++) begin
            xs = x + beam_t'(shadow_scroll_x[i]);
            ys = y + beam_t'(shadow_scroll_y[i]);
            if (!found && shadow_enable[i] && (xs[shadow_shift[i]] != ys[shadow_shift[i]])) begin
                result = shadow_color[i];
                if (i == 0 && cop_active && y > 3) begin
                    result = copper_color;
                end
                found = 1'b1;
            end
        end
        return result;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            track_bx <= '0;
            track_by <= '0;
        end else if (track_bx == beam_t'(h_total - 1)) begin
            track_bx <= '0;
            track_by <= (track_by == beam_t'(v_total - 1)) ? '0 : track_by + 1'b1;
        end else begin
            track_bx <= track_bx + 1'b1;
        end
        track_x1 <= track_bx;
        track_y1 <= track_by;
        track_px <= track_x1;
        track_py <= track_y1;
        track_valid <= !reset;
    end

    always @(negedge clk) begin
        color_t want;
        if (track_valid) begin
            // the copper frame starts and ends on pixel 0,0
            if (track_px == '0 && track_py == '0) begin
                if (cop_active) begin
                    shadow_color[0] = copper_color;
                    cop_active = 1'b0;
                end else if (cop_pending) begin
                    cop_active = 1'b1;
                    cop_pending = 1'b0;
                end
            end
            assert (pixel_x == track_px) else report_mismatch("pixel_x", pixel_x, track_px);
            assert (pixel_y == track_py) else report_mismatch("pixel_y", pixel_y, track_py);
            if (quiet_count > 0) begin
                quiet_count--;
            end else if (!(cop_active && track_py == 3)) begin
                want = expected_pixel(track_px, track_py);
                assert (pixel == want) else report_mismatch("pixel", pixel, want);
            end
        end
    end

    initial begin
        steps_ready = 1'b0;
        wait (steps_ready);
        #(steps.size() * 20 * frame_cycles * 20);
        report_problem("watchdog expired before the transaction table finished");
    end

    initial begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        reset = 1'b1;
        track_valid = 1'b0;
        lfsr_state = 32'h8055;
        shadow_bg = '0;
        for (int i = 0; i < layer_count; i++) begin
            shadow_scroll_x[i] = '0;
            shadow_scroll_y[i] = '0;
            shadow_color[i] = '0;
            shadow_enable[i] = 1'b0;
            shadow_shift[i] = '0;
        end
        cop_pending = 1'b0;
        cop_active = 1'b0;
        quiet_count = 0;
        build_steps();
        steps_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (wb_ack == 1'b0) else report_mismatch("wb_ack", wb_ack, 0);
        foreach (steps[i]) begin
            if (steps[i].sync_line >= 0) begin
                while (!(track_bx == '0 && track_by == beam_t'(steps[i].sync_line))) begin
                    @(negedge clk);
                end
            end
            bus_cycle(steps[i]);
            repeat (steps[i].frames * frame_cycles) @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* vdp.f */
verilog/vdp_pkg.sv
verilog/vdp_raster.sv
verilog/vdp_host_interface.sv
verilog/vdp_copper.sv
verilog/vdp_layer.sv
verilog/vdp_mixer.sv
verilog/vdp_top.sv
bench/vdp_tb.sv

/* Bender.yml */
package:
  name: vdp

sources:
  - verilog/vdp_pkg.sv
  - verilog/vdp_raster.sv
  - verilog/vdp_host_interface.sv
  - verilog/vdp_copper.sv
  - verilog/vdp_layer.sv
  - verilog/vdp_mixer.sv
  - verilog/vdp_top.sv
  - target: test
    files:
      - bench/vdp_tb.sv
